// ==== source/ex_macros.svh ====
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// data path and pc width
`define XLEN 64

// register index width, x0..x31
`define REG_ADDR_W 5

// width of the *w word forms
`define WORD_W 32

// sequential pc increment, no compressed instructions
`define PC_STEP 4

`endif

// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // operation class as seen by the execute stage
    typedef enum logic [3:0] {
        lui,
        auipc,
        jal,
        jalr,
        branch,
        load,
        store,
        op_imm,
        op_reg,
        op_imm_w,
        op_reg_w,
        none
    } op_class_e;

    // funct3 codes, alu view
    typedef enum logic [2:0] {
        f3_add  = 3'b000,
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101,
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } funct3_e;

    // branch view of the same codes
    localparam funct3_e f3_beq  = f3_add;
    localparam funct3_e f3_bne  = f3_sll;
    localparam funct3_e f3_blt  = f3_xor;
    localparam funct3_e f3_bge  = f3_sr;
    localparam funct3_e f3_bltu = f3_or;
    localparam funct3_e f3_bgeu = f3_and;

    // alu operation select
    typedef enum logic [3:0] {
        add,
        sub,
        slt,
        sltu,
        and_op,
        or_op,
        xor_op,
        sll,
        srl,
        sra
    } alu_op_e;

endpackage

// ==== source/ex_pipe_pkg.sv ====
`include "ex_macros.svh"

package ex_pipe_pkg;
    import rv_isa_pkg::*;

    // decode payload held in the id/ex register
    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        op_class_e              op;
        funct3_e                funct3;
        // instruction bit 30, selects sub and sra
        logic                   funct7_alt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        // register file values read in decode
        logic [`XLEN-1:0]       src_a;
        logic [`XLEN-1:0]       src_b;
        logic [`XLEN-1:0]       imm;
    } id_ex_t;

    // register write of a later stage, seen as a bypass source
    typedef struct packed {
        logic                   wen;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } bypass_t;

    // result handed to mem
    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        op_class_e              op;
        logic [`REG_ADDR_W-1:0] rd;
        // link address for jumps, address for loads and stores
        logic [`XLEN-1:0]       alu_out;
        logic [`XLEN-1:0]       store_data;
    } ex_mem_t;

    // fetch redirect on jumps and mispredicted branches
    typedef struct packed {
        logic                   pc_update;
        logic [`XLEN-1:0]       dnpc;
    } redirect_t;

endpackage

// ==== source/ex_alu.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_alu import rv_isa_pkg::*; (
    input  alu_op_e          op,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    output logic [`XLEN-1:0] result
);

    localparam int unsigned sh_w = $clog2(`XLEN);

    logic [sh_w-1:0] shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    // shifts use b modulo 64
    assign shamt = b[sh_w-1:0];

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            add:    result = a + b;
            sub:    result = a - b;
            // compares return 0 or 1
            slt:    result = {{(`XLEN-1){1'b0}}, lt_signed};
            sltu:   result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            and_op: result = a & b;
            or_op:  result = a | b;
            xor_op: result = a ^ b;
            sll:    result = a << shamt;
            srl:    result = a >> shamt;
            // arithmetic, sign bit refills from the left
            sra:    result = $unsigned($signed(a) >>> shamt);
            default: result = a + b;
        endcase
    end

endmodule

// ==== source/ex_input_reg.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_input_reg import ex_pipe_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  logic   in_valid,
    input  id_ex_t in_data,
    input  logic   advance,
    output logic   out_valid,
    output id_ex_t out_data
);

    // valid bit, cleared on reset and on redirect flush
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;
        end
    end

    // payload only moves when the stage advances
    // contents are meaningless while out_valid is low
    always_ff @(posedge clk) begin
        if (advance) begin
            out_data <= in_data;
        end
    end

    // a stalled item must not change under mem back-pressure
    hold_stable_a: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !advance |=> $stable(out_data)
    ) else $error("ex_input_reg: payload changed while held");

endmodule

// ==== source/ex_forward.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_forward import rv_isa_pkg::*; import ex_pipe_pkg::*; (
    input  id_ex_t           item,
    input  bypass_t          mem_bypass,
    input  bypass_t          wb_bypass,
    output logic [`XLEN-1:0] src1,
    output logic [`XLEN-1:0] src2
);

    logic reads_rs2;
    logic mem_hit1;
    logic wb_hit1;
    logic mem_hit2;
    logic wb_hit2;

    // later stage writes this source register, x0 excluded
    function automatic logic hit(bypass_t by, logic [`REG_ADDR_W-1:0] rs);
        hit = by.wen && (by.rd == rs) && (rs != '0);
    endfunction

    // only these classes actually read rs2
    assign reads_rs2 = item.op inside {branch, store, op_reg, op_reg_w};

    assign mem_hit1 = hit(mem_bypass, item.rs1);
    assign wb_hit1  = hit(wb_bypass, item.rs1);
    assign mem_hit2 = reads_rs2 && hit(mem_bypass, item.rs2);
    assign wb_hit2  = reads_rs2 && hit(wb_bypass, item.rs2);

    // mem is younger than wb, so it wins
    always_comb begin
        if (mem_hit1) begin
            src1 = mem_bypass.data;
        end else if (wb_hit1) begin
            src1 = wb_bypass.data;
        end else begin
            src1 = item.src_a;
        end
    end

    always_comb begin
        if (mem_hit2) begin
            src2 = mem_bypass.data;
        end else if (wb_hit2) begin
            src2 = wb_bypass.data;
        end else begin
            src2 = item.src_b;
        end
    end

    // x0 reads the decode value whatever later stages drive
    always_comb begin
        x0_no_bypass_a: assert final (
            (item.rs1 != '0 || src1 == item.src_a) &&
            (item.rs2 != '0 || src2 == item.src_b)
        ) else $error("ex_forward: x0 source was bypassed");
    end

endmodule

// ==== source/ex_execute.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_execute import rv_isa_pkg::*; import ex_pipe_pkg::*; (
    input  id_ex_t           item,
    input  logic [`XLEN-1:0] src1,
    input  logic [`XLEN-1:0] src2,
    output logic [`XLEN-1:0] alu_out,
    output logic [`XLEN-1:0] alu_raw
);

    // shift amount widths, 6 bits full width and 5 bits word
    localparam int unsigned sh_w  = $clog2(`XLEN);
    localparam int unsigned shw_w = $clog2(`WORD_W);
    localparam logic [`XLEN-1:0] pc_step = `PC_STEP;

    logic             word_op;
    logic             imm_form;
    logic             reg_form;
    logic             shift_op;
    logic             word_sr;
    logic [`XLEN-1:0] shamt_src;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    alu_op_e          alu_op;

    assign word_op  = item.op inside {op_imm_w, op_reg_w};
    assign imm_form = item.op inside {op_imm, op_imm_w};
    assign reg_form = item.op inside {op_reg, op_reg_w};
    assign shift_op = (imm_form || reg_form) && (item.funct3 inside {f3_sll, f3_sr});
    // srlw/sraw/srliw/sraiw run on the upper half
    assign word_sr  = word_op && (item.funct3 == f3_sr);

    // shift amount comes from the immediate or rs2
    assign shamt_src = imm_form ? item.imm : src2;

    // operand a
    always_comb begin
        case (item.op)
            lui:             op_a = '0;
            auipc, jal, jalr: op_a = item.pc;
            default: begin
                // low word moved up so the shift fills from bit 63
                if (word_sr) begin
                    op_a = {src1[`WORD_W-1:0], {(`XLEN-`WORD_W){1'b0}}};
                end else begin
                    op_a = src1;
                end
            end
        endcase
    end

    // operand b
    always_comb begin
        if (item.op inside {jal, jalr}) begin
            // link address pc + 4
            op_b = pc_step;
        end else if (shift_op && word_op) begin
            op_b = {{(`XLEN-shw_w){1'b0}}, shamt_src[shw_w-1:0]};
        end else if (shift_op) begin
            op_b = {{(`XLEN-sh_w){1'b0}}, shamt_src[sh_w-1:0]};
        end else if (imm_form || item.op inside {load, store, lui, auipc}) begin
            op_b = item.imm;
        end else begin
            // register forms and branch compare
            op_b = src2;
        end
    end

    // alu operation decode
    always_comb begin
        alu_op = add;
        if (item.op == branch) begin
            // difference feeds the branch compare
            alu_op = sub;
        end else if (imm_form || reg_form) begin
            case (item.funct3)
                // funct7_alt on addi is an imm bit, not a sub
                f3_add:  alu_op = (reg_form && item.funct7_alt) ? sub : add;
                f3_sll:  alu_op = sll;
                f3_slt:  alu_op = slt;
                f3_sltu: alu_op = sltu;
                f3_xor:  alu_op = xor_op;
                f3_sr:   alu_op = item.funct7_alt ? sra : srl;
                f3_or:   alu_op = or_op;
                f3_and:  alu_op = and_op;
                default: alu_op = add;
            endcase
        end
    end

    ex_alu u_alu (
        .op     (alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_raw)
    );

    // word results are sign extended from bit 31
    always_comb begin
        if (word_sr) begin
            alu_out = {{(`XLEN-`WORD_W){alu_raw[`XLEN-1]}}, alu_raw[`XLEN-1:`WORD_W]};
        end else if (word_op) begin
            alu_out = {{(`XLEN-`WORD_W){alu_raw[`WORD_W-1]}}, alu_raw[`WORD_W-1:0]};
        end else begin
            alu_out = alu_raw;
        end
    end

endmodule

// ==== source/ex_branch.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_branch import rv_isa_pkg::*; import ex_pipe_pkg::*; (
    input  id_ex_t           item,
    input  logic             valid,
    input  logic             fire,
    input  logic [`XLEN-1:0] src1,
    input  logic [`XLEN-1:0] diff,
    output redirect_t        redirect
);

    localparam logic [`XLEN-1:0] pc_step = `PC_STEP;

    logic             is_jump;
    logic             is_branch;
    logic [`XLEN-1:0] src2_rec;
    logic             sign_differs;
    logic             lt_signed;
    logic             lt_unsigned;
    logic             taken;
    logic             predict_taken;
    logic [`XLEN-1:0] next_pc;

    // class decode only, the item valid arrives through fire
    assign is_jump   = item.op inside {jal, jalr};
    assign is_branch = item.op == branch;

    // rs2 sign recovered from src1 - diff
    assign src2_rec     = src1 - diff;
    assign sign_differs = src1[`XLEN-1] ^ src2_rec[`XLEN-1];

    // equal signs cannot overflow, so the difference sign decides
    // otherwise the operand signs decide directly
    assign lt_signed   = sign_differs ? src1[`XLEN-1] : diff[`XLEN-1];
    // borrow out of the subtract
    assign lt_unsigned = sign_differs ? src2_rec[`XLEN-1] : diff[`XLEN-1];

    always_comb begin
        case (item.funct3)
            f3_beq:  taken = (diff == '0);
            f3_bne:  taken = (diff != '0);
            f3_blt:  taken = lt_signed;
            f3_bge:  taken = !lt_signed;
            f3_bltu: taken = lt_unsigned;
            f3_bgeu: taken = !lt_unsigned;
            default: taken = 1'b0;
        endcase
    end

    // static btfn, backward branches were fetched as taken
    assign predict_taken = item.imm[`XLEN-1];

    // jalr target, then jal and forward branches, then fall-through
    always_comb begin
        if (item.op == jalr) begin
            next_pc = src1 + item.imm;
        end else if (item.op == jal || (item.op == branch && !predict_taken)) begin
            next_pc = item.pc + item.imm;
        end else begin
            // backward branch resolved not taken
            next_pc = item.pc + pc_step;
        end
    end

    assign redirect.pc_update = fire && (is_jump || (is_branch && (taken != predict_taken)));
    assign redirect.dnpc      = next_pc;

    // fire comes from the stage top and must carry the item valid
    always_comb begin
        redirect_valid_a: assert final (!redirect.pc_update || valid)
            else $error("ex_branch: redirect without a valid item");
    end

endmodule

// ==== source/ex_stage.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_stage import ex_pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      branch_flush,
    input  logic      id_valid,
    output logic      id_ready,
    input  id_ex_t    id_data,
    input  bypass_t   mem_bypass,
    input  bypass_t   wb_bypass,
    output logic      ex_valid,
    input  logic      mem_ready,
    output ex_mem_t   ex_data,
    output redirect_t redirect
);

    logic             advance;
    logic             fire;
    id_ex_t           cur;
    logic [`XLEN-1:0] src1;
    logic [`XLEN-1:0] src2;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] alu_raw;

    // single-cycle execute, so ready passes straight through
    assign id_ready = mem_ready;
    // register loads whenever decode may transfer
    assign advance  = id_ready;
    // item leaves toward mem this edge
    assign fire     = ex_valid && mem_ready;

    ex_input_reg u_input_reg (
        .clk       (clk),
        .rst       (rst),
        .flush     (branch_flush),
        .in_valid  (id_valid),
        .in_data   (id_data),
        .advance   (advance),
        .out_valid (ex_valid),
        .out_data  (cur)
    );

    ex_forward u_forward (
        .item       (cur),
        .mem_bypass (mem_bypass),
        .wb_bypass  (wb_bypass),
        .src1       (src1),
        .src2       (src2)
    );

    ex_execute u_execute (
        .item    (cur),
        .src1    (src1),
        .src2    (src2),
        .alu_out (alu_out),
        .alu_raw (alu_raw)
    );

    // branch compare reuses the alu subtract
    ex_branch u_branch (
        .item     (cur),
        .valid    (ex_valid),
        .fire     (fire),
        .src1     (src1),
        .diff     (alu_raw),
        .redirect (redirect)
    );

    // store data is the forwarded rs2 value
    assign ex_data.pc         = cur.pc;
    assign ex_data.op         = cur.op;
    assign ex_data.rd         = cur.rd;
    assign ex_data.alu_out    = alu_out;
    assign ex_data.store_data = src2;

endmodule

// ==== testbench/tb_ex_model.svh ====
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// operand value after mem/wb bypass, mem first, x0 never replaced
function automatic logic [`XLEN-1:0] bypassed(
    input logic [`REG_ADDR_W-1:0] rs,
    input logic [`XLEN-1:0]       reg_value,
    input bypass_t                mem_by,
    input bypass_t                wb_by
);
    logic [`XLEN-1:0] value;
    value = reg_value;
    if (rs != '0) begin
        if (mem_by.wen && mem_by.rd == rs) begin
            value = mem_by.data;
        end else if (wb_by.wen && wb_by.rd == rs) begin
            value = wb_by.data;
        end
    end
    return value;
endfunction

// classes with an rs2 operand
function automatic logic reads_rs2(input op_class_e op);
    return op inside {branch, store, op_reg, op_reg_w};
endfunction

// word result widened from bit 31
function automatic logic [`XLEN-1:0] sext_word(input logic [`WORD_W-1:0] w);
    return {{(`XLEN-`WORD_W){w[`WORD_W-1]}}, w};
endfunction

// full width alu forms, selected by funct3
function automatic logic [`XLEN-1:0] full_width_op(
    input funct3_e          f3,
    input logic             alt,
    input logic             is_reg,
    input logic [`XLEN-1:0] a,
    input logic [`XLEN-1:0] b
);
    logic [`XLEN-1:0] r;
    case (f3)
        f3_add:  r = (is_reg && alt) ? a - b : a + b;
        f3_sll:  r = a << b[5:0];
        f3_slt:  r = {{(`XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
        f3_sltu: r = {{(`XLEN-1){1'b0}}, (a < b)};
        f3_xor:  r = a ^ b;
        f3_sr: begin
            // arithmetic shift kept in a signed expression of its own
            if (alt) begin
                r = $signed(a) >>> b[5:0];
            end else begin
                r = a >> b[5:0];
            end
        end
        f3_or:   r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// expected payload toward mem for one item
function automatic ex_mem_t expected_ex_mem(
    input id_ex_t  it,
    input bypass_t mem_by,
    input bypass_t wb_by
);
    ex_mem_t          res;
    logic [`XLEN-1:0] s1;
    logic [`XLEN-1:0] s2;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] step;
    logic [`WORD_W-1:0] w;
    logic             is_reg;
    step   = `PC_STEP;
    s1     = bypassed(it.rs1, it.src_a, mem_by, wb_by);
    s2     = reads_rs2(it.op) ? bypassed(it.rs2, it.src_b, mem_by, wb_by) : it.src_b;
    is_reg = it.op inside {op_reg, op_reg_w};
    b      = is_reg ? s2 : it.imm;
    res.pc         = it.pc;
    res.op         = it.op;
    res.rd         = it.rd;
    res.store_data = s2;
    case (it.op)
        lui:         res.alu_out = it.imm;
        auipc:       res.alu_out = it.pc + it.imm;
        jal, jalr:   res.alu_out = it.pc + step;
        branch:      res.alu_out = s1 - s2;
        load, store: res.alu_out = s1 + it.imm;
        op_imm, op_reg: begin
            res.alu_out = full_width_op(it.funct3, it.funct7_alt, is_reg, s1, b);
        end
        op_imm_w, op_reg_w: begin
            // 32-bit arithmetic, then widened
            case (it.funct3)
                f3_add: w = (is_reg && it.funct7_alt) ? s1[31:0] - b[31:0] : s1[31:0] + b[31:0];
                f3_sll: w = s1[31:0] << b[4:0];
                f3_sr: begin
                    if (it.funct7_alt) begin
                        w = $signed(s1[31:0]) >>> b[4:0];
                    end else begin
                        w = s1[31:0] >> b[4:0];
                    end
                end
                default: begin
                    w = `WORD_W'(full_width_op(it.funct3, it.funct7_alt, is_reg, s1, b));
                end
            endcase
            res.alu_out = sext_word(w);
        end
        default:     res.alu_out = s1 + s2;
    endcase
    return res;
endfunction

// branch outcome straight from the operands
function automatic logic branch_taken(
    input funct3_e          f3,
    input logic [`XLEN-1:0] s1,
    input logic [`XLEN-1:0] s2
);
    logic t;
    case (f3)
        f3_beq:  t = (s1 == s2);
        f3_bne:  t = (s1 != s2);
        f3_blt:  t = ($signed(s1) < $signed(s2));
        f3_bge:  t = !($signed(s1) < $signed(s2));
        f3_bltu: t = (s1 < s2);
        f3_bgeu: t = !(s1 < s2);
        default: t = 1'b0;
    endcase
    return t;
endfunction

// expected redirect for an item that leaves the stage
function automatic redirect_t expected_redirect(
    input id_ex_t  it,
    input bypass_t mem_by,
    input bypass_t wb_by
);
    redirect_t        red;
    logic [`XLEN-1:0] s1;
    logic [`XLEN-1:0] s2;
    logic [`XLEN-1:0] step;
    logic             backward;
    step     = `PC_STEP;
    s1       = bypassed(it.rs1, it.src_a, mem_by, wb_by);
    s2       = bypassed(it.rs2, it.src_b, mem_by, wb_by);
    // negative offset was fetched as taken
    backward = it.imm[`XLEN-1];
    red.pc_update = (it.op inside {jal, jalr}) ||
                    (it.op == branch && branch_taken(it.funct3, s1, s2) != backward);
    if (it.op == jalr) begin
        red.dnpc = s1 + it.imm;
    end else if (it.op == jal || (it.op == branch && !backward)) begin
        red.dnpc = it.pc + it.imm;
    end else begin
        red.dnpc = it.pc + step;
    end
    return red;
endfunction

`endif

// ==== testbench/tb_ex_stage.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module tb_ex_stage import rv_isa_pkg::*; import ex_pipe_pkg::*; ();

    localparam int n_items      = 1500;
    localparam int reset_cycles = 5;

    logic      clk;
    logic      rst;
    logic      branch_flush;
    logic      id_valid;
    logic      id_ready;
    id_ex_t    id_data;
    bypass_t   mem_bypass;
    bypass_t   wb_bypass;
    logic      ex_valid;
    logic      mem_ready;
    ex_mem_t   ex_data;
    redirect_t redirect;

    integer    seed = 32'h2e98;
    // items accepted by the stage and not yet seen leaving
    id_ex_t    pending[$];
    int        checked = 0;
    int        discarded = 0;

    `include "tb_ex_model.svh"

    ex_stage u_ex_stage (
        .clk          (clk),
        .rst          (rst),
        .branch_flush (branch_flush),
        .id_valid     (id_valid),
        .id_ready     (id_ready),
        .id_data      (id_data),
        .mem_bypass   (mem_bypass),
        .wb_bypass    (wb_bypass),
        .ex_valid     (ex_valid),
        .mem_ready    (mem_ready),
        .ex_data      (ex_data),
        .redirect     (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        abort_run($sformatf("[FAIL] %s expected 0x%h actual 0x%h at %0t", name, exp, act,
                            $time));
    endtask

    task automatic check_ex_mem(input ex_mem_t exp, input ex_mem_t act);
        if (exp.pc !== act.pc) begin
            report_mismatch("ex_data.pc", exp.pc, act.pc);
        end else if (exp.op !== act.op) begin
            report_mismatch("ex_data.op", 64'(exp.op), 64'(act.op));
        end else if (exp.rd !== act.rd) begin
            report_mismatch("ex_data.rd", 64'(exp.rd), 64'(act.rd));
        end else if (exp.alu_out !== act.alu_out) begin
            report_mismatch("ex_data.alu_out", exp.alu_out, act.alu_out);
        end else if (exp.store_data !== act.store_data) begin
            report_mismatch("ex_data.store_data", exp.store_data, act.store_data);
        end
    endtask

    // target only matters when fetch is redirected
    task automatic check_redirect(input redirect_t exp, input redirect_t act);
        if (exp.pc_update !== act.pc_update) begin
            report_mismatch("redirect.pc_update", 64'(exp.pc_update), 64'(act.pc_update));
        end else if (exp.pc_update && exp.dnpc !== act.dnpc) begin
            report_mismatch("redirect.dnpc", exp.dnpc, act.dnpc);
        end
    endtask

    // small register indices so bypass hits and x0 show up often
    function automatic id_ex_t random_item();
        id_ex_t      it;
        logic [31:0] r;
        logic [31:0] r2;
        logic [2:0]  f3;
        r  = $random(seed);
        r2 = $random(seed);
        it.op         = op_class_e'(r[3:0] % 4'd11);
        it.funct7_alt = r[4];
        it.rd         = {3'b000, r[6:5]};
        it.rs1        = {3'b000, r[8:7]};
        it.rs2        = {3'b000, r[10:9]};
        it.pc         = {$random(seed), $random(seed)};
        it.pc[1:0]    = 2'b00;
        it.src_a      = {$random(seed), $random(seed)};
        // equal operands now and then for beq/bge
        it.src_b      = (r[12:11] == 2'b00) ? it.src_a : {$random(seed), $random(seed)};
        f3 = r[15:13];
        if (it.op == branch) begin
            // skip the two unused branch codes
            if (f3 == 3'd2 || f3 == 3'd3) begin
                f3 = f3 + 3'd2;
            end
        end else if (it.op inside {op_imm_w, op_reg_w}) begin
            f3 = (r[14:13] == 2'd0) ? 3'd0 : (r[14:13] == 2'd1) ? 3'd1 : 3'd5;
        end
        it.funct3 = funct3_e'(f3);
        if (it.op inside {lui, auipc}) begin
            it.imm = {{32{r2[31]}}, r2[31:12], 12'b0};
        end else if (it.op inside {branch, jal}) begin
            it.imm = {{51{r2[12]}}, r2[12:1], 1'b0};
        end else begin
            it.imm = {{52{r2[11]}}, r2[11:0]};
        end
        return it;
    endfunction

    function automatic bypass_t random_bypass();
        bypass_t     by;
        logic [31:0] r;
        r = $random(seed);
        by.wen  = r[0];
        by.rd   = {3'b000, r[2:1]};
        by.data = {$random(seed), $random(seed)};
        return by;
    endfunction

    // pre-edge values, inputs move later in the step by nba
    initial begin : compare_results
        id_ex_t    head;
        ex_mem_t   exp_data;
        redirect_t exp_redir;
        forever begin
            @(posedge clk);
            if (id_ready !== mem_ready) begin
                report_mismatch("id_ready", 64'(mem_ready), 64'(id_ready));
            end
            if (rst || branch_flush) begin
                // register item dropped, nothing accepted this edge
                discarded = discarded + pending.size();
                pending.delete();
            end else begin
                if (ex_valid !== (pending.size() != 0)) begin
                    abort_run($sformatf("ex_valid is %b with %0d accepted items waiting at %0t",
                                        ex_valid, pending.size(), $time));
                end
                if (ex_valid && mem_ready) begin
                    head      = pending.pop_front();
                    exp_data  = expected_ex_mem(head, mem_bypass, wb_bypass);
                    exp_redir = expected_redirect(head, mem_bypass, wb_bypass);
                    check_ex_mem(exp_data, ex_data);
                    check_redirect(exp_redir, redirect);
                    checked = checked + 1;
                end else if (redirect.pc_update !== 1'b0) begin
                    report_mismatch("redirect.pc_update", 64'(1'b0), 64'(redirect.pc_update));
                end
                if (id_valid && mem_ready) begin
                    pending.push_back(id_data);
                end
            end
        end
    end

    initial begin : drive_stimulus
        integer      sent;
        logic [31:0] ctl;
        sent         = 0;
        rst          = 1'b1;
        branch_flush = 1'b0;
        id_valid     = 1'b0;
        id_data      = '0;
        mem_ready    = 1'b0;
        mem_bypass   = '0;
        wb_bypass    = '0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        while (sent < n_items) begin
            ctl = $random(seed);
            if (ctl[5:0] == 6'd0) begin
                // flush or short reset with the pipe otherwise idle
                rst          <= (ctl[8:6] == 3'd0);
                branch_flush <= (ctl[8:6] != 3'd0);
                id_valid     <= 1'b0;
                mem_ready    <= 1'b0;
            end else begin
                rst          <= 1'b0;
                branch_flush <= 1'b0;
                mem_ready    <= (ctl[7:6] != 2'b00);
                // stalled offer stays put until taken
                if (!id_valid || id_ready) begin
                    id_valid <= (ctl[9:8] != 2'b00);
                    id_data  <= random_item();
                end
            end
            mem_bypass <= random_bypass();
            wb_bypass  <= random_bypass();
            @(posedge clk);
            if (id_valid && id_ready && !rst && !branch_flush) begin
                sent = sent + 1;
            end
        end
        id_valid     <= 1'b0;
        rst          <= 1'b0;
        branch_flush <= 1'b0;
        mem_ready    <= 1'b1;
        // let the last item leave
        do begin
            @(posedge clk);
        end while (ex_valid);
        @(negedge clk);
        $display("%0d items checked, %0d discarded", checked, discarded);
        if (pending.size() == 0 && checked > 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run($sformatf("run ended with %0d items pending and %0d checked",
                                pending.size(), checked));
        end
    end

    // worst case about 20 cycles per item
    initial begin : watchdog
        repeat (n_items * 20 + reset_cycles) @(posedge clk);
        abort_run("timeout: the stage did not drain all items in time");
    end

endmodule

// ==== list.f ====
+incdir+source
+incdir+testbench
source/rv_isa_pkg.sv
source/ex_pipe_pkg.sv
source/ex_alu.sv
source/ex_input_reg.sv
source/ex_forward.sv
source/ex_execute.sv
source/ex_branch.sv
source/ex_stage.sv
testbench/tb_ex_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the execute stage testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module tb_ex_stage -f list.f -o tb_ex_stage \
    || { echo "verilator build failed"; exit 1; }
sim_out=$(./obj_dir/tb_ex_stage)
echo "$sim_out"
echo "$sim_out" | grep -q "Simulation PASSED" && exit 0 || exit 1
